/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module router_tb -f sim.f \
  -o router_sim && ./obj_dir/router_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TEST PASSED$" sim.log && exit 0 || exit 1

/* sim.f */
+incdir+verif
source/router_pkg.sv
source/input_port.sv
source/output_arbiter.sv
source/switch_fabric.sv
source/host_regs.sv
source/router.sv
verif/router_tb.sv

/* source/host_regs.sv */
////////////////////
// Host register block. Returns the device id, holds the port lock
// register (write ones to clear) and counts completed frames per
// input and per output. Reads answer one cycle after the strobe.
////////////////////
`timescale 1ns/1ns
`default_nettype none

module host_regs (
  input  logic                   clk,
  input  logic                   reset_n,
  input  router_pkg::host_req_t  host,
  input  router_pkg::port_vec_t  frame_n,
  input  router_pkg::port_vec_t  frameo_n,
  output router_pkg::port_vec_t  lock,
  output router_pkg::host_resp_t host_resp
);

  router_pkg::port_vec_t frame_prev_n;
  router_pkg::port_vec_t frameo_prev_n;
  router_pkg::port_vec_t frame_done;
  router_pkg::port_vec_t frameo_done;
  router_pkg::word_t     in_count [router_pkg::num_ports];
  router_pkg::word_t     out_count [router_pkg::num_ports];
  router_pkg::addr_t     in_offset;
  router_pkg::addr_t     out_offset;
  router_pkg::word_t     read_data;
  router_pkg::word_t     rdata_q;
  logic                  rd_valid_q;

  // a frame completes on the rising edge of its frame signal
  assign frame_done  = ~frame_prev_n & frame_n;
  assign frameo_done = ~frameo_prev_n & frameo_n;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      frame_prev_n  <= '1;
      frameo_prev_n <= '1;
    end else begin
      frame_prev_n  <= frame_n;
      frameo_prev_n <= frameo_n;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < router_pkg::num_ports; i++) begin
        in_count[i]  <= '0;
        out_count[i] <= '0;
      end
    end else begin
      for (int i = 0; i < router_pkg::num_ports; i++) begin
        if (frame_done[i]) begin
          in_count[i] <= in_count[i] + 1'b1;
        end
        if (frameo_done[i]) begin
          out_count[i] <= out_count[i] + 1'b1;
        end
      end
    end
  end

  // all ports start frozen
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      lock <= '1;
    end else if (host.wr && (host.address == router_pkg::lock_addr)) begin
      lock <= lock & ~router_pkg::port_vec_t'(host.wdata);
    end
  end

  assign in_offset  = host.address - router_pkg::in_count_base;
  assign out_offset = host.address - router_pkg::out_count_base;

  // unmapped addresses read as zero
  always_comb begin
    read_data = '0;
    if (host.address == router_pkg::id_addr) begin
      read_data = router_pkg::host_id;
    end else if (host.address == router_pkg::lock_addr) begin
      read_data = router_pkg::word_t'(lock);
    end else if (in_offset < router_pkg::addr_t'(router_pkg::num_ports)) begin
      read_data = in_count[router_pkg::port_t'(in_offset)];
    end else if (out_offset < router_pkg::addr_t'(router_pkg::num_ports)) begin
      read_data = out_count[router_pkg::port_t'(out_offset)];
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= host.rd;
    end
  end

  always_ff @(posedge clk) begin
    if (host.rd) begin
      rdata_q <= read_data;
    end
  end

  assign host_resp.rd_valid = rd_valid_q;
  assign host_resp.rdata    = rdata_q;

  assert property (@(posedge clk) disable iff (!reset_n) host_resp.rd_valid == $past(host.rd))
    else $error("read response not one cycle after read strobe");

endmodule

`default_nettype wire

/* source/input_port.sv */
////////////////////
// Input port of the router. Collects the destination from the serial
// header, checks the pad bits, requests the destination output and
// waits for its grant, then holds until the frame ends.
////////////////////
`timescale 1ns/1ns
`default_nettype none

module input_port #(
  parameter int port_index = 0
) (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  din,
  input  logic                  frame_n,
  input  logic                  lock,
  input  router_pkg::port_vec_t grant_n,
  output router_pkg::port_vec_t request_n,
  output logic                  busy_n
);

  router_pkg::port_state_e state;
  router_pkg::port_t       dest;
  router_pkg::cnt_t        cnt;
  logic                    in_pad;
  logic                    abort;

  // cnt counts elapsed pad cycles and saturates once the pad is over
  assign in_pad = (state != router_pkg::idle_addr) && (state != router_pkg::forward) &&
                  (cnt != router_pkg::cnt_t'(router_pkg::pad_cycles));

  assign abort = frame_n | (in_pad & ~din);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= router_pkg::idle_addr;
      dest  <= '0;
      cnt   <= '0;
    end else if (!lock) begin
      if ((state != router_pkg::idle_addr) && abort) begin
        // frame ended or bad pad bit, drop the packet
        state <= router_pkg::idle_addr;
        cnt   <= '0;
      end else begin
        case (state)
          router_pkg::idle_addr: begin
            if (frame_n) begin
              cnt <= '0;
            end else begin
              // address arrives lsb first
              dest <= {din, dest[router_pkg::port_bits-1:1]};
              if (cnt == router_pkg::cnt_t'(router_pkg::port_bits - 1)) begin
                state <= router_pkg::pad;
                cnt   <= '0;
              end else begin
                cnt <= cnt + 1'b1;
              end
            end
          end
          router_pkg::pad: begin
            cnt <= cnt + 1'b1;
            if (cnt == router_pkg::cnt_t'(router_pkg::pad_cycles - 3)) begin
              state <= router_pkg::request;
            end
          end
          router_pkg::request: begin
            cnt   <= cnt + 1'b1;
            state <= router_pkg::wait_grant;
          end
          router_pkg::wait_grant: begin
            if (in_pad) begin
              cnt <= cnt + 1'b1;
            end
            if (!grant_n[dest]) begin
              state <= router_pkg::forward;
            end
          end
          router_pkg::forward: begin
            // held until frame_n rises
            state <= router_pkg::forward;
          end
          default: state <= router_pkg::idle_addr;
        endcase
      end
    end
  end

  always_comb begin
    request_n = '1;
    if (((state == router_pkg::request) || (state == router_pkg::wait_grant)) && !abort) begin
      request_n[dest] = 1'b0;
    end
  end

  // busy while the destination is taken by another input
  assign busy_n = !((state == router_pkg::wait_grant) && grant_n[dest]);

  assert property (@(posedge clk) disable iff (!reset_n) $onehot0(~request_n))
    else $error("input port %0d requests more than one output", port_index);

endmodule

`default_nettype wire

/* source/output_arbiter.sv */
////////////////////
// Round-robin arbiter of one output port. Grants one requesting input
// for a single cycle and holds the connection until that input's
// registered frame ends.
////////////////////
`timescale 1ns/1ns
`default_nettype none

module output_arbiter (
  input  logic                  clk,
  input  logic                  reset_n,
  input  router_pkg::port_vec_t request_n,
  input  router_pkg::port_vec_t frame_reg_n,
  input  logic                  lock,
  output router_pkg::port_vec_t grant_n,
  output router_pkg::port_t     src,
  output logic                  connected
);

  router_pkg::arb_state_e state;
  router_pkg::port_t      pick;
  router_pkg::port_t      cand;
  logic                   hit;

  // search starts just after the last winner, held in src
  always_comb begin
    hit  = 1'b0;
    pick = src;
    cand = src;
    for (int k = router_pkg::num_ports; k >= 1; k--) begin
      cand = src + router_pkg::port_t'(k);
      if (!request_n[cand]) begin
        hit  = 1'b1;
        pick = cand;
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= router_pkg::arb_idle;
      // input 0 has first priority after reset
      src   <= router_pkg::port_t'(router_pkg::num_ports - 1);
    end else if (!lock) begin
      case (state)
        router_pkg::arb_idle: begin
          if (hit) begin
            state <= router_pkg::arb_grant;
            src   <= pick;
          end
        end
        router_pkg::arb_grant: state <= router_pkg::arb_connect;
        router_pkg::arb_connect: begin
          if (frame_reg_n[src]) begin
            state <= router_pkg::arb_idle;
          end
        end
        default: state <= router_pkg::arb_idle;
      endcase
    end
  end

  always_comb begin
    grant_n = '1;
    if (state == router_pkg::arb_grant) begin
      grant_n[src] = 1'b0;
    end
  end

  assign connected = (state != router_pkg::arb_idle);

  assert property (@(posedge clk) disable iff (!reset_n) $onehot0(~grant_n))
    else $error("more than one input granted");

  // a grant always comes out of an idle arbiter and leads to a connection
  assert property (@(posedge clk) disable iff (!reset_n)
    (grant_n != '1) |-> (state == router_pkg::arb_grant) && $past(hit))
    else $error("grant outside arb_grant");

endmodule

`default_nettype wire

/* source/router.sv */
////////////////////
// Top level of the serial packet router. Ties the input ports,
// the per-output arbiters, the switch fabric and the host block
// together and transposes the request and grant matrices.
////////////////////
`timescale 1ns/1ns
`default_nettype none

module router (
  input  logic                   clk,
  input  logic                   reset_n,
  input  router_pkg::port_vec_t  din,
  input  router_pkg::port_vec_t  frame_n,
  input  router_pkg::port_vec_t  valid_n,
  output router_pkg::port_vec_t  dout,
  output router_pkg::port_vec_t  frameo_n,
  output router_pkg::port_vec_t  valido_n,
  output router_pkg::port_vec_t  busy_n,
  input  router_pkg::host_req_t  host,
  output router_pkg::host_resp_t host_resp
);

  // rows of the *_by_in matrices are inputs, rows of *_by_out are outputs
  router_pkg::port_vec_t [router_pkg::num_ports-1:0] req_by_in;
  router_pkg::port_vec_t [router_pkg::num_ports-1:0] req_by_out;
  router_pkg::port_vec_t [router_pkg::num_ports-1:0] grant_by_out;
  router_pkg::port_vec_t [router_pkg::num_ports-1:0] grant_by_in;
  router_pkg::port_t     [router_pkg::num_ports-1:0] src;
  router_pkg::port_vec_t                             connected;
  router_pkg::port_vec_t                             frame_reg_n;
  router_pkg::port_vec_t                             lock;

  for (genvar i = 0; i < router_pkg::num_ports; i++) begin : g_in
    input_port #(.port_index(i)) u_input_port (
      .clk       (clk),
      .reset_n   (reset_n),
      .din       (din[i]),
      .frame_n   (frame_n[i]),
      .lock      (lock[i]),
      .grant_n   (grant_by_in[i]),
      .request_n (req_by_in[i]),
      .busy_n    (busy_n[i])
    );
  end

  for (genvar j = 0; j < router_pkg::num_ports; j++) begin : g_out
    output_arbiter u_output_arbiter (
      .clk         (clk),
      .reset_n     (reset_n),
      .request_n   (req_by_out[j]),
      .frame_reg_n (frame_reg_n),
      .lock        (lock[j]),
      .grant_n     (grant_by_out[j]),
      .src         (src[j]),
      .connected   (connected[j])
    );
  end

  for (genvar i = 0; i < router_pkg::num_ports; i++) begin : g_row
    for (genvar j = 0; j < router_pkg::num_ports; j++) begin : g_col
      assign req_by_out[j][i]  = req_by_in[i][j];
      assign grant_by_in[i][j] = grant_by_out[j][i];
    end
  end

  switch_fabric u_switch_fabric (
    .clk         (clk),
    .din         (din),
    .frame_n     (frame_n),
    .valid_n     (valid_n),
    .src         (src),
    .connected   (connected),
    .frame_reg_n (frame_reg_n),
    .dout        (dout),
    .frameo_n    (frameo_n),
    .valido_n    (valido_n)
  );

  host_regs u_host_regs (
    .clk       (clk),
    .reset_n   (reset_n),
    .host      (host),
    .frame_n   (frame_n),
    .frameo_n  (frameo_n),
    .lock      (lock),
    .host_resp (host_resp)
  );

endmodule

`default_nettype wire

/* source/router_pkg.sv */
////////////////////
// Shared definitions for the serial packet router: port count, widths,
// host register map, device id and the types passed between blocks.
// Every router file refers to these by scoped name.
////////////////////
`default_nettype none

package router_pkg;

  localparam int num_ports  = 4;
  localparam int port_bits  = 2;
  localparam int pad_cycles = 4;

  // header and pad cycles share one counter in the input port
  localparam int cnt_bits = $clog2(port_bits + pad_cycles + 1);

  typedef logic [port_bits-1:0] port_t;
  typedef logic [num_ports-1:0] port_vec_t;
  typedef logic [cnt_bits-1:0]  cnt_t;
  typedef logic [15:0]          word_t;
  typedef logic [15:0]          addr_t;

  // host register map
  localparam addr_t id_addr        = 16'h0000;
  localparam addr_t lock_addr      = 16'h0100;
  localparam addr_t in_count_base  = 16'h2000;
  localparam addr_t out_count_base = 16'h2010;

  localparam logic [7:0] chip_id = 8'h5a;
  localparam logic [7:0] rev_id  = 8'h03;
  localparam word_t      host_id = {chip_id, rev_id};

  typedef struct packed {
    logic  wr;
    logic  rd;
    addr_t address;
    word_t wdata;
  } host_req_t;

  typedef struct packed {
    logic  rd_valid;
    word_t rdata;
  } host_resp_t;

  typedef enum logic [2:0] {idle_addr, pad, request, wait_grant, forward} port_state_e;

  typedef enum logic [1:0] {arb_idle, arb_grant, arb_connect} arb_state_e;

endpackage

`default_nettype wire

/* source/switch_fabric.sv */
////////////////////
// Switch fabric. Samples the serial inputs once and drives each output
// from the input its arbiter selected. Outputs without a connection
// stay idle high.
////////////////////
`timescale 1ns/1ns
`default_nettype none

module switch_fabric (
  input  logic                                          clk,
  input  router_pkg::port_vec_t                         din,
  input  router_pkg::port_vec_t                         frame_n,
  input  router_pkg::port_vec_t                         valid_n,
  input  router_pkg::port_t [router_pkg::num_ports-1:0] src,
  input  router_pkg::port_vec_t                         connected,
  output router_pkg::port_vec_t                         frame_reg_n,
  output router_pkg::port_vec_t                         dout,
  output router_pkg::port_vec_t                         frameo_n,
  output router_pkg::port_vec_t                         valido_n
);

  router_pkg::port_vec_t din_reg;
  router_pkg::port_vec_t valid_reg_n;

  always_ff @(posedge clk) begin
    din_reg     <= din;
    frame_reg_n <= frame_n;
    valid_reg_n <= valid_n;
  end

  always_comb begin
    for (int j = 0; j < router_pkg::num_ports; j++) begin
      frameo_n[j] = frame_reg_n[src[j]] | ~connected[j];
      valido_n[j] = valid_reg_n[src[j]] | ~connected[j];
      // dout idles high outside valid bits
      dout[j]     = din_reg[src[j]] | valid_reg_n[src[j]] | ~connected[j];
    end
  end

endmodule

`default_nettype wire

/* verif/router_tb_tasks.svh */
////////////////////
// Directed test tasks of the router testbench. Sends serial packets,
// collects them from the outputs and accesses the host registers.
// Included inside the testbench module.
////////////////////

task automatic send_packet(input int src, input router_pkg::port_t dest,
                           input router_pkg::word_t data);
  // destination lsb first, then pad ones, then payload msb first
  for (int b = 0; b < router_pkg::port_bits; b++) begin
    @(negedge clk);
    frame_n[src] = 1'b0;
    valid_n[src] = 1'b1;
    din[src]     = dest[b];
  end
  for (int p = 0; p < router_pkg::pad_cycles; p++) begin
    @(negedge clk);
    din[src] = 1'b1;
  end
  for (int k = payload_bits - 1; k >= 0; k--) begin
    @(negedge clk);
    din[src]     = data[k];
    valid_n[src] = 1'b0;
    frame_n[src] = (k == 0);
  end
  @(negedge clk);
  din[src]     = 1'b1;
  valid_n[src] = 1'b1;
  frame_n[src] = 1'b1;
  sent_count[src]++;
endtask

task automatic collect_packet(input int port, output router_pkg::word_t data,
                              output int bits);
  int   wait_cycles;
  logic done;
  data        = '0;
  bits        = 0;
  wait_cycles = 0;
  done        = 1'b0;
  @(negedge clk);
  while (frameo_n[port] && (wait_cycles < frame_timeout)) begin
    @(negedge clk);
    wait_cycles++;
  end
  if (frameo_n[port]) begin
    $display("Timeout: no frame started on output %0d", port);
    timeout_count++;
    return;
  end
  wait_cycles = 0;
  while (!done && (wait_cycles < frame_timeout)) begin
    if (!valido_n[port]) begin
      data = {data[14:0], dout[port]};
      bits++;
    end
    if (frameo_n[port]) begin
      done = 1'b1;
    end else begin
      @(negedge clk);
      wait_cycles++;
    end
  end
  if (!done) begin
    $display("Timeout: frame on output %0d never ended", port);
    timeout_count++;
  end else begin
    got_count[port]++;
  end
endtask

task automatic host_write(input router_pkg::addr_t address, input router_pkg::word_t data);
  @(negedge clk);
  host.wr      = 1'b1;
  host.address = address;
  host.wdata   = data;
  @(negedge clk);
  host = '0;
endtask

task automatic host_read(input router_pkg::addr_t address, output router_pkg::word_t data);
  int wait_cycles;
  data        = '0;
  wait_cycles = 0;
  @(negedge clk);
  host.rd      = 1'b1;
  host.address = address;
  @(negedge clk);
  host = '0;
  while (!host_resp.rd_valid && (wait_cycles < read_timeout)) begin
    @(negedge clk);
    wait_cycles++;
  end
  if (!host_resp.rd_valid) begin
    $display("Timeout: no read response for address 0x%h", address);
    timeout_count++;
  end else begin
    data = host_resp.rdata;
  end
endtask

task automatic test_lock();
  router_pkg::word_t value;
  router_pkg::word_t data;
  compare_vec("busy_n after reset", busy_n, '1);
  compare_vec("frameo_n after reset", frameo_n, '1);
  compare_vec("valido_n after reset", valido_n, '1);
  host_read(router_pkg::id_addr, value);
  compare_word("host id", value, 16'h5a03);
  host_read(router_pkg::lock_addr, value);
  compare_word("lock after reset", value, 16'h000f);
  // a frozen router must not start any output frame
  random_byte(data);
  active_seen = '0;
  send_packet(0, 2'd2, data);
  repeat (8) @(negedge clk);
  compare_vec("outputs active while locked", active_seen, '0);
  host_write(router_pkg::lock_addr, 16'h000f);
  host_read(router_pkg::lock_addr, value);
  compare_word("lock after clear", value, 16'h0000);
endtask

task automatic test_routing();
  router_pkg::word_t data;
  router_pkg::word_t got;
  int                bits;
  for (int s = 0; s < router_pkg::num_ports; s++) begin
    for (int d = 0; d < router_pkg::num_ports; d++) begin
      random_byte(data);
      active_seen = '0;
      fork
        send_packet(s, router_pkg::port_t'(d), data);
        collect_packet(d, got, bits);
      join
      compare_word($sformatf("payload %0d->%0d", s, d), got, data);
      compare_word($sformatf("length %0d->%0d", s, d), router_pkg::word_t'(bits),
                   router_pkg::word_t'(payload_bits));
      compare_vec($sformatf("outputs active %0d->%0d", s, d), active_seen,
                  router_pkg::port_vec_t'(1 << d));
      last_winner[d] = router_pkg::port_t'(s);
    end
  end
endtask

task automatic test_parallel();
  router_pkg::word_t data [router_pkg::num_ports];
  router_pkg::word_t got [router_pkg::num_ports];
  int                bits [router_pkg::num_ports];
  for (int i = 0; i < router_pkg::num_ports; i++) begin
    random_byte(data[i]);
  end
  active_seen = '0;
  // input i goes to output i + 1
  fork
    send_packet(0, 2'd1, data[0]);
    send_packet(1, 2'd2, data[1]);
    send_packet(2, 2'd3, data[2]);
    send_packet(3, 2'd0, data[3]);
    collect_packet(1, got[0], bits[0]);
    collect_packet(2, got[1], bits[1]);
    collect_packet(3, got[2], bits[2]);
    collect_packet(0, got[3], bits[3]);
  join
  for (int i = 0; i < router_pkg::num_ports; i++) begin
    compare_word($sformatf("parallel payload from %0d", i), got[i], data[i]);
    compare_word($sformatf("parallel length from %0d", i), router_pkg::word_t'(bits[i]),
                 router_pkg::word_t'(payload_bits));
    last_winner[(i + 1) % router_pkg::num_ports] = router_pkg::port_t'(i);
  end
  compare_vec("parallel outputs active", active_seen, '1);
endtask

task automatic test_contention(input router_pkg::port_t a, input router_pkg::port_t b,
                               input router_pkg::port_t dest);
  router_pkg::word_t data_a;
  router_pkg::word_t data_b;
  router_pkg::word_t got;
  router_pkg::port_t winner;
  router_pkg::port_t loser;
  router_pkg::port_t seen_winner;
  int                bits;
  winner = expected_winner(last_winner[dest], a, b);
  loser  = (winner == a) ? b : a;
  random_byte(data_a);
  random_byte(data_b);
  active_seen = '0;
  busy_seen   = '0;
  fork
    send_packet(int'(a), dest, data_a);
    send_packet(int'(b), dest, data_b);
    collect_packet(int'(dest), got, bits);
  join
  repeat (4) @(negedge clk);
  seen_winner = busy_seen[a] ? b : a;
  compare_port("contention winner", seen_winner, winner);
  compare_word("contention payload", got, (winner == a) ? data_a : data_b);
  compare_vec("busy inputs", busy_seen, router_pkg::port_vec_t'(1 << loser));
  compare_vec("contention outputs active", active_seen, router_pkg::port_vec_t'(1 << dest));
  last_winner[dest] = winner;
endtask

task automatic test_counters();
  router_pkg::word_t value;
  for (int i = 0; i < router_pkg::num_ports; i++) begin
    host_read(router_pkg::addr_t'(router_pkg::in_count_base + i), value);
    compare_word($sformatf("in_count[%0d]", i), value, router_pkg::word_t'(sent_count[i]));
    host_read(router_pkg::addr_t'(router_pkg::out_count_base + i), value);
    compare_word($sformatf("out_count[%0d]", i), value, router_pkg::word_t'(got_count[i]));
  end
endtask

/* verif/router_tb.sv */
////////////////////
// Testbench for the serial packet router. Drives the serial inputs and
// the host strobe bus, runs the directed tests in order and checks each
// response against the expected packet and register values.
////////////////////
`timescale 1ns/1ns
`default_nettype none

module router_tb;

  localparam int payload_bits  = 8;
  localparam int frame_timeout = 40;
  localparam int read_timeout  = 4;

  logic                   clk = 1'b0;
  logic                   reset_n;
  router_pkg::port_vec_t  din;
  router_pkg::port_vec_t  frame_n;
  router_pkg::port_vec_t  valid_n;
  router_pkg::port_vec_t  dout;
  router_pkg::port_vec_t  frameo_n;
  router_pkg::port_vec_t  valido_n;
  router_pkg::port_vec_t  busy_n;
  router_pkg::host_req_t  host;
  router_pkg::host_resp_t host_resp;

  logic [7:0]            lfsr_state;
  int                    error_count;
  int                    timeout_count;
  int                    sent_count [router_pkg::num_ports];
  int                    got_count [router_pkg::num_ports];
  router_pkg::port_t     last_winner [router_pkg::num_ports];
  router_pkg::port_vec_t active_seen;
  router_pkg::port_vec_t busy_seen;

  router uut (
    .clk       (clk),
    .reset_n   (reset_n),
    .din       (din),
    .frame_n   (frame_n),
    .valid_n   (valid_n),
    .dout      (dout),
    .frameo_n  (frameo_n),
    .valido_n  (valido_n),
    .busy_n    (busy_n),
    .host      (host),
    .host_resp (host_resp)
  );

  always #20 clk = ~clk;

  // outputs that started a frame and inputs that reported busy
  always @(negedge clk) begin
    active_seen = active_seen | ~frameo_n;
    busy_seen   = busy_seen | ~busy_n;
  end

  // taps 8, 6, 5, 4
  function automatic logic [7:0] lfsr_next(input logic [7:0] state);
    return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
  endfunction

  task automatic random_byte(output router_pkg::word_t value);
    value = '0;
    for (int k = 0; k < payload_bits; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[14:0], lfsr_state[0]};
    end
  endtask

  // first of the two contenders found after the last winner
  function automatic router_pkg::port_t expected_winner(input router_pkg::port_t last,
                                                        input router_pkg::port_t a,
                                                        input router_pkg::port_t b);
    router_pkg::port_t cand;
    cand = last;
    for (int k = 1; k <= router_pkg::num_ports; k++) begin
      cand = router_pkg::port_t'((int'(last) + k) % router_pkg::num_ports);
      if ((cand == a) || (cand == b)) begin
        return cand;
      end
    end
    return a;
  endfunction

  task automatic compare_word(input string name, input router_pkg::word_t got,
                              input router_pkg::word_t exp);
    if (got !== exp) begin
      $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_vec(input string name, input router_pkg::port_vec_t got,
                             input router_pkg::port_vec_t exp);
    if (got !== exp) begin
      $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_port(input string name, input router_pkg::port_t got,
                              input router_pkg::port_t exp);
    if (got !== exp) begin
      $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
      error_count++;
    end
  endtask

  initial begin
    error_count   = 0;
    timeout_count = 0;
    lfsr_state    = 8'd50;
    active_seen   = '0;
    busy_seen     = '0;
    for (int i = 0; i < router_pkg::num_ports; i++) begin
      sent_count[i]  = 0;
      got_count[i]   = 0;
      last_winner[i] = router_pkg::port_t'(router_pkg::num_ports - 1);
    end
    din     = '1;
    frame_n = '1;
    valid_n = '1;
    host    = '0;
    reset_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    test_lock();
    // first contention right after reset, so input 0 has priority
    test_contention(2'd0, 2'd2, 2'd1);
    test_contention(2'd0, 2'd2, 2'd1);
    test_routing();
    test_parallel();
    test_counters();

    $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
    if ((error_count == 0) && (timeout_count == 0)) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  `include "router_tb_tasks.svh"

endmodule

`default_nettype wire
